/* project.f */
+incdir+src
src/exec_pkg.sv
src/pipe_slice.sv
src/alu.sv
src/branch_resolve.sv
src/exec_ctrl.sv
src/exec_unit.sv
verif/exec_checker.sv
verif/exec_tb.sv

/* run.sh */
#!/bin/sh
# compile and run the execute stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module exec_tb -f project.f

out=$(./obj_dir/Vexec_tb)
printf '%s\n' "$out"

# pass only when the pass message shows up as a line of its own
printf '%s\n' "$out" | grep -qx "Done: no errors"

/* src/alu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exec_defines.svh"

module alu
	import exec_pkg::*;
(
	input  logic                  I_clk,
	input  logic                  I_reset,
	input  logic                  start,
	input  alu_op_e               op,
	input  logic [`EXEC_XLEN-1:0] op_a,
	input  logic [`EXEC_XLEN-1:0] op_b,
	output logic                  busy,
	output logic                  done,
	output logic [`EXEC_XLEN-1:0] result,
	output alu_flags_t            flags
);

	logic [`EXEC_XLEN-1:0]    sum;
	logic [`EXEC_XLEN:0]      diff;
	logic [`EXEC_XLEN-1:0]    and_v;
	logic [`EXEC_XLEN-1:0]    or_v;
	logic [`EXEC_XLEN-1:0]    xor_v;
	logic                     lt;
	logic                     ltu;
	logic                     eq;
	logic                     is_shift;
	logic                     take;
	logic [`EXEC_SHAMT_W-1:0] shcnt;
	alu_op_e                  sh_op;

	// ######################################################################
	// combinational arithmetic and compare
	// ######################################################################

	always_comb begin
		sum   = op_a + op_b;
		// extra top bit is the borrow
		diff  = {1'b0, op_a} - {1'b0, op_b};
		and_v = op_a & op_b;
		or_v  = op_a | op_b;
		xor_v = op_a ^ op_b;
	end

	// borrow gives unsigned less-than and a sign mismatch flips it for signed
	assign ltu = diff[`EXEC_XLEN];
	assign lt  = diff[`EXEC_XLEN] ^ xor_v[`EXEC_XLEN-1];
	assign eq  = (diff[`EXEC_XLEN-1:0] == '0);

	assign is_shift = (op == OP_SLL) || (op == OP_SRL) || (op == OP_SRA);
	assign take     = start && !busy;

	// ######################################################################
	// busy, done and the shift counter
	// ######################################################################

	always_ff @(posedge I_clk) begin
		if (I_reset) begin
			busy  <= 1'b0;
			done  <= 1'b0;
			shcnt <= '0;
		end else begin
			done <= 1'b0;
			if (take) begin
				if (is_shift) begin
					busy  <= 1'b1;
					shcnt <= op_b[`EXEC_SHAMT_W-1:0];
				end else begin
					done <= 1'b1;
				end
			end else if (busy) begin
				if (shcnt != '0) begin
					shcnt <= shcnt - 1'b1;
				end else begin
					// count exhausted so the result is final
					busy <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

	// ######################################################################
	// result, flags and shift datapath
	// ######################################################################

	always_ff @(posedge I_clk) begin
		if (take) begin
			flags <= '{lt: lt, ltu: ltu, eq: eq};
			sh_op <= op;
			case (op)
				OP_SUB:  result <= diff[`EXEC_XLEN-1:0];
				OP_AND:  result <= and_v;
				OP_OR:   result <= or_v;
				OP_XOR:  result <= xor_v;
				OP_SLT:  result <= {{(`EXEC_XLEN-1){1'b0}}, lt};
				OP_SLTU: result <= {{(`EXEC_XLEN-1){1'b0}}, ltu};
				// shifts start from the unshifted operand
				OP_SLL, OP_SRL, OP_SRA: result <= op_a;
				default: result <= sum;
			endcase
		end else if (busy && shcnt != '0) begin
			// one bit per cycle
			case (sh_op)
				OP_SLL:  result <= {result[`EXEC_XLEN-2:0], 1'b0};
				OP_SRL:  result <= {1'b0, result[`EXEC_XLEN-1:1]};
				default: result <= {result[`EXEC_XLEN-1], result[`EXEC_XLEN-1:1]};
			endcase
		end
	end

	// controller must wait for a running shift to finish
	a_no_start_when_busy: assert property (
		@(posedge I_clk) disable iff (I_reset)
		busy |-> !start
	) else $error("alu: start raised while busy");

endmodule

`default_nettype wire

/* src/branch_resolve.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exec_defines.svh"

module branch_resolve
	import exec_pkg::*;
(
	input  br_cond_e              cond,
	input  alu_flags_t            flags,
	input  logic [`EXEC_XLEN-1:0] pc,
	input  logic [`EXEC_XLEN-1:0] imm,
	output logic                  taken,
	output logic [`EXEC_XLEN-1:0] target,
	output logic                  misaligned
);

	// condition decode
	always_comb begin
		case (cond)
			BR_EQ:   taken = flags.eq;
			BR_NE:   taken = !flags.eq;
			BR_LT:   taken = flags.lt;
			BR_GE:   taken = !flags.lt;
			BR_LTU:  taken = flags.ltu;
			BR_GEU:  taken = !flags.ltu;
			// plain alu op is never a branch
			default: taken = 1'b0;
		endcase
	end

	// pc relative target
	assign target = pc + imm;

	// only a taken branch can fault on alignment
	assign misaligned = taken && (target[1:0] != 2'b00);

endmodule

`default_nettype wire

/* src/exec_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exec_defines.svh"

module exec_ctrl
	import exec_pkg::*;
(
	input  logic                  I_clk,
	input  logic                  I_reset,
	input  logic                  req_valid,
	output logic                  req_ready,
	input  exec_req_t             req_data,
	output logic                  rsp_valid,
	input  logic                  rsp_ready,
	output exec_rsp_t             rsp_data,
	output logic                  alu_start,
	output alu_op_e               alu_op,
	output logic [`EXEC_XLEN-1:0] alu_a,
	output logic [`EXEC_XLEN-1:0] alu_b,
	input  logic                  alu_busy,
	input  logic                  alu_done,
	input  logic [`EXEC_XLEN-1:0] alu_result,
	output br_cond_e              br_cond,
	output logic [`EXEC_XLEN-1:0] br_pc,
	output logic [`EXEC_XLEN-1:0] br_imm,
	input  logic                  br_taken,
	input  logic [`EXEC_XLEN-1:0] br_target,
	input  logic                  br_misaligned
);

	typedef enum logic [1:0] {S_IDLE, S_RUN, S_HOLD} state_e;

	state_e    state;
	logic      start_pend;
	exec_req_t req_q;
	exec_rsp_t rsp_q;

	assign req_ready = (state == S_IDLE);
	assign rsp_valid = (state == S_HOLD);
	assign rsp_data  = rsp_q;

	// ######################################################################
	// operand selection from the held request
	// ######################################################################

	assign alu_op = req_q.op;
	assign alu_a  = (req_q.a_sel == A_PC) ? req_q.pc : req_q.rs1;
	assign alu_b  = (req_q.b_sel == B_IMM) ? req_q.imm : req_q.rs2;

	assign br_cond = req_q.cond;
	assign br_pc   = req_q.pc;
	assign br_imm  = req_q.imm;

	// start goes out one cycle after accept, once the alu is free
	assign alu_start = start_pend && !alu_busy;

	// ######################################################################
	// state machine
	// ######################################################################

	always_ff @(posedge I_clk) begin
		if (I_reset) begin
			state      <= S_IDLE;
			start_pend <= 1'b0;
		end else begin
			if (alu_start) begin
				start_pend <= 1'b0;
			end
			case (state)
				S_IDLE: begin
					if (req_valid) begin
						state      <= S_RUN;
						start_pend <= 1'b1;
					end
				end
				S_RUN: begin
					if (alu_done) begin
						state <= S_HOLD;
					end
				end
				// wait for the output slice
				default: begin
					if (rsp_ready) begin
						state <= S_IDLE;
					end
				end
			endcase
		end
	end

	always_ff @(posedge I_clk) begin
		if (req_valid && req_ready) begin
			req_q <= req_data;
		end
		if (state == S_RUN && alu_done) begin
			rsp_q.rd         <= req_q.rd;
			rsp_q.result     <= alu_result;
			rsp_q.taken      <= br_taken;
			rsp_q.target     <= br_target;
			rsp_q.misaligned <= br_misaligned;
		end
	end

	// done only answers a start issued from run
	a_no_done_in_idle: assert property (
		@(posedge I_clk) disable iff (I_reset)
		state == S_IDLE |-> !alu_done
	) else $error("exec_ctrl: alu done while idle");

endmodule

`default_nettype wire

/* src/exec_defines.svh */
`ifndef EXEC_DEFINES_SVH
`define EXEC_DEFINES_SVH

// ######################################################################
// datapath widths
// ######################################################################

`define EXEC_XLEN    32
`define EXEC_SHAMT_W 5
`define EXEC_RD_W    5

// ######################################################################
// 4-bit alu operation codes
// ######################################################################

`define ALUOP_ADD  4'd0
`define ALUOP_SUB  4'd1
`define ALUOP_AND  4'd2
`define ALUOP_OR   4'd3
`define ALUOP_XOR  4'd4
`define ALUOP_SLT  4'd5
`define ALUOP_SLTU 4'd6
`define ALUOP_SLL  4'd7
`define ALUOP_SRL  4'd8
`define ALUOP_SRA  4'd9

`endif

/* src/exec_pkg.sv */
`default_nettype none

`include "exec_defines.svh"

package exec_pkg;

	// alu operations with codes from the defines header
	typedef enum logic [3:0] {
		OP_ADD  = `ALUOP_ADD,
		OP_SUB  = `ALUOP_SUB,
		OP_AND  = `ALUOP_AND,
		OP_OR   = `ALUOP_OR,
		OP_XOR  = `ALUOP_XOR,
		OP_SLT  = `ALUOP_SLT,
		OP_SLTU = `ALUOP_SLTU,
		OP_SLL  = `ALUOP_SLL,
		OP_SRL  = `ALUOP_SRL,
		OP_SRA  = `ALUOP_SRA
	} alu_op_e;

	// operand selects
	typedef enum logic {A_RS1, A_PC} a_sel_e;
	typedef enum logic {B_RS2, B_IMM} b_sel_e;

	// conditional branch kinds where none marks a plain alu op
	typedef enum logic [2:0] {
		BR_NONE,
		BR_EQ,
		BR_NE,
		BR_LT,
		BR_GE,
		BR_LTU,
		BR_GEU
	} br_cond_e;

	typedef struct packed {
		alu_op_e               op;
		a_sel_e                a_sel;
		b_sel_e                b_sel;
		br_cond_e              cond;
		logic [`EXEC_RD_W-1:0] rd;
		logic [`EXEC_XLEN-1:0] pc;
		logic [`EXEC_XLEN-1:0] rs1;
		logic [`EXEC_XLEN-1:0] rs2;
		logic [`EXEC_XLEN-1:0] imm;
	} exec_req_t;

	typedef struct packed {
		logic [`EXEC_RD_W-1:0] rd;
		logic [`EXEC_XLEN-1:0] result;
		logic                  taken;
		logic [`EXEC_XLEN-1:0] target;
		logic                  misaligned;
	} exec_rsp_t;

	// comparison flags registered by the alu
	typedef struct packed {
		logic lt;
		logic ltu;
		logic eq;
	} alu_flags_t;

endpackage

`default_nettype wire

/* src/exec_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exec_defines.svh"

module exec_unit
	import exec_pkg::*;
(
	input  logic      I_clk,
	input  logic      I_reset,
	input  logic      in_valid,
	output logic      in_ready,
	input  exec_req_t in_data,
	output logic      out_valid,
	input  logic      out_ready,
	output exec_rsp_t out_data
);

	logic                  req_valid;
	logic                  req_ready;
	exec_req_t             req_data;
	logic                  rsp_valid;
	logic                  rsp_ready;
	exec_rsp_t             rsp_data;
	logic                  alu_start;
	alu_op_e               alu_op;
	logic [`EXEC_XLEN-1:0] alu_a;
	logic [`EXEC_XLEN-1:0] alu_b;
	logic                  alu_busy;
	logic                  alu_done;
	logic [`EXEC_XLEN-1:0] alu_result;
	alu_flags_t            alu_flags;
	br_cond_e              br_cond;
	logic [`EXEC_XLEN-1:0] br_pc;
	logic [`EXEC_XLEN-1:0] br_imm;
	logic                  br_taken;
	logic [`EXEC_XLEN-1:0] br_target;
	logic                  br_misaligned;

	// ######################################################################
	// request slice, control, alu, branch, response slice
	// ######################################################################

	pipe_slice #(.T(exec_req_t)) req_slice_i (
		.I_clk     (I_clk),
		.I_reset   (I_reset),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_data   (in_data),
		.out_valid (req_valid),
		.out_ready (req_ready),
		.out_data  (req_data)
	);

	exec_ctrl ctrl_i (
		.I_clk         (I_clk),
		.I_reset       (I_reset),
		.req_valid     (req_valid),
		.req_ready     (req_ready),
		.req_data      (req_data),
		.rsp_valid     (rsp_valid),
		.rsp_ready     (rsp_ready),
		.rsp_data      (rsp_data),
		.alu_start     (alu_start),
		.alu_op        (alu_op),
		.alu_a         (alu_a),
		.alu_b         (alu_b),
		.alu_busy      (alu_busy),
		.alu_done      (alu_done),
		.alu_result    (alu_result),
		.br_cond       (br_cond),
		.br_pc         (br_pc),
		.br_imm        (br_imm),
		.br_taken      (br_taken),
		.br_target     (br_target),
		.br_misaligned (br_misaligned)
	);

	alu alu_i (
		.I_clk   (I_clk),
		.I_reset (I_reset),
		.start   (alu_start),
		.op      (alu_op),
		.op_a    (alu_a),
		.op_b    (alu_b),
		.busy    (alu_busy),
		.done    (alu_done),
		.result  (alu_result),
		.flags   (alu_flags)
	);

	branch_resolve br_i (
		.cond       (br_cond),
		.flags      (alu_flags),
		.pc         (br_pc),
		.imm        (br_imm),
		.taken      (br_taken),
		.target     (br_target),
		.misaligned (br_misaligned)
	);

	pipe_slice #(.T(exec_rsp_t)) rsp_slice_i (
		.I_clk     (I_clk),
		.I_reset   (I_reset),
		.in_valid  (rsp_valid),
		.in_ready  (rsp_ready),
		.in_data   (rsp_data),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_data  (out_data)
	);

endmodule

`default_nettype wire

/* src/pipe_slice.sv */
`timescale 1ns/1ps
`default_nettype none

module pipe_slice #(
	parameter type T = logic
) (
	input  logic I_clk,
	input  logic I_reset,
	input  logic in_valid,
	output logic in_ready,
	input  T     in_data,
	output logic out_valid,
	input  logic out_ready,
	output T     out_data
);

	logic full;
	T     data_q;

	// accept when empty or when the held entry leaves this cycle
	assign in_ready  = !full || out_ready;
	assign out_valid = full;
	assign out_data  = data_q;

	always_ff @(posedge I_clk) begin
		if (I_reset) begin
			full <= 1'b0;
		end else if (in_valid && in_ready) begin
			full <= 1'b1;
		end else if (out_ready) begin
			full <= 1'b0;
		end
	end

	always_ff @(posedge I_clk) begin
		if (in_valid && in_ready) begin
			data_q <= in_data;
		end
	end

	// stalled output must hold its payload
	a_stable_when_stalled: assert property (
		@(posedge I_clk) disable iff (I_reset)
		out_valid && !out_ready |=> $stable(out_data)
	) else $error("pipe_slice: out_data changed while stalled");

endmodule

`default_nettype wire

/* verif/exec_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exec_defines.svh"

module exec_checker
	import exec_pkg::*;
(
	input  logic      I_clk,
	input  logic      I_reset,
	input  logic      in_valid,
	input  logic      in_ready,
	input  exec_req_t in_data,
	input  logic      out_valid,
	input  logic      out_ready,
	input  exec_rsp_t out_data,
	input  int        test_id,
	input  logic      end_test,
	output int        pending,
	output int        checks,
	output int        errors
);

	localparam int N_TESTS = 6;

	exec_req_t req_q[$];
	int        id_q[$];
	int        checked_n [N_TESTS];
	int        err_n [N_TESTS];
	logic      reset_q;

	function automatic string test_name(input int id);
		case (id)
			0:       return "reset_state";
			1:       return "arith_logic";
			2:       return "compare";
			3:       return "shift";
			4:       return "branch";
			default: return "backpressure";
		endcase
	endfunction

	// expected response straight from the instruction rules
	function automatic exec_rsp_t ref_exec(input exec_req_t r);
		exec_rsp_t             e;
		logic [`EXEC_XLEN-1:0] a;
		logic [`EXEC_XLEN-1:0] b;
		logic [4:0]            sh;
		a    = (r.a_sel == A_PC) ? r.pc : r.rs1;
		b    = (r.b_sel == B_IMM) ? r.imm : r.rs2;
		sh   = b[4:0];
		e.rd = r.rd;
		case (r.op)
			OP_ADD:  e.result = a + b;
			OP_SUB:  e.result = a - b;
			OP_AND:  e.result = a & b;
			OP_OR:   e.result = a | b;
			OP_XOR:  e.result = a ^ b;
			OP_SLT:  e.result = {31'd0, $signed(a) < $signed(b)};
			OP_SLTU: e.result = {31'd0, a < b};
			OP_SLL:  e.result = a << sh;
			OP_SRL:  e.result = a >> sh;
			default: e.result = $signed(a) >>> sh;
		endcase
		case (r.cond)
			BR_EQ:   e.taken = (a == b);
			BR_NE:   e.taken = (a != b);
			BR_LT:   e.taken = ($signed(a) < $signed(b));
			BR_GE:   e.taken = ($signed(a) >= $signed(b));
			BR_LTU:  e.taken = (a < b);
			BR_GEU:  e.taken = (a >= b);
			default: e.taken = 1'b0;
		endcase
		e.target     = r.pc + r.imm;
		e.misaligned = e.taken && (e.target[1:0] != 2'b00);
		return e;
	endfunction

	task automatic check_field(input int id, input string field,
		input logic [`EXEC_XLEN-1:0] expd, input logic [`EXEC_XLEN-1:0] act);
		checked_n[id]++;
		checks++;
		if (expd !== act) begin
			$display("[ERROR] %s: %s expected %h actual %h", test_name(id), field, expd, act);
			err_n[id]++;
			errors++;
		end
	endtask

	always @(posedge I_clk) begin
		exec_rsp_t expd;
		int        id;
		if (I_reset) begin
			req_q.delete();
			id_q.delete();
			for (int i = 0; i < N_TESTS; i++) begin
				checked_n[i] = 0;
				err_n[i]     = 0;
			end
			pending = 0;
			checks  = 0;
			errors  = 0;
		end else begin
			// first edge after reset release
			if (reset_q) begin
				check_field(0, "out_valid", `EXEC_XLEN'(0), `EXEC_XLEN'(out_valid));
				check_field(0, "in_ready", `EXEC_XLEN'(1), `EXEC_XLEN'(in_ready));
			end
			if (in_valid && in_ready) begin
				req_q.push_back(in_data);
				id_q.push_back(test_id);
			end
			if (out_valid && out_ready) begin
				if (req_q.size() == 0) begin
					$display("response arrived with no request outstanding");
					errors++;
				end else begin
					id   = id_q.pop_front();
					expd = ref_exec(req_q.pop_front());
					check_field(id, "rd", `EXEC_XLEN'(expd.rd), `EXEC_XLEN'(out_data.rd));
					check_field(id, "result", expd.result, out_data.result);
					check_field(id, "taken", `EXEC_XLEN'(expd.taken),
						`EXEC_XLEN'(out_data.taken));
					check_field(id, "target", expd.target, out_data.target);
					check_field(id, "misaligned", `EXEC_XLEN'(expd.misaligned),
						`EXEC_XLEN'(out_data.misaligned));
				end
			end
			pending = req_q.size();
			if (end_test) begin
				$display("test %s: %0d checked, %0d errors", test_name(test_id),
					checked_n[test_id], err_n[test_id]);
			end
		end
		reset_q = I_reset;
	end

endmodule

`default_nettype wire

/* verif/exec_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exec_defines.svh"

module exec_tb
	import exec_pkg::*;
();

	localparam int          RESET_CYCLES = 16;
	localparam int          N_INSTR      = 348;
	localparam int          CYCLE_LIMIT  = N_INSTR * 40 + RESET_CYCLES;
	localparam logic [31:0] SEED         = 32'h07df6b51;

	localparam alu_op_e  ARITH_OPS [5] = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR};
	localparam alu_op_e  SHIFT_OPS [3] = '{OP_SLL, OP_SRL, OP_SRA};
	localparam alu_op_e  ALL_OPS [10]  = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
		OP_SLT, OP_SLTU, OP_SLL, OP_SRL, OP_SRA};
	localparam br_cond_e BR_CONDS [6]  = '{BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU};
	// equal, less, greater, and signed less but unsigned greater
	localparam logic [31:0] BR_A [4] = '{32'h1234, 32'h10, 32'h20, 32'hfffffff0};
	localparam logic [31:0] BR_B [4] = '{32'h1234, 32'h20, 32'h10, 32'h3};

	logic        I_clk;
	logic        I_reset;
	logic        in_valid;
	logic        in_ready;
	exec_req_t   in_data;
	logic        out_valid;
	logic        out_ready = 1'b1;
	exec_rsp_t   out_data;
	int          test_id;
	logic        end_test;
	logic        throttle;
	int          pending;
	int          checks;
	int          errors;
	int          cycles    = 0;
	int          run_left  = 0;
	logic [31:0] lfsr_stim = SEED;
	logic [31:0] lfsr_bp   = SEED;

	exec_unit dut_i (
		.I_clk     (I_clk),
		.I_reset   (I_reset),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_data   (in_data),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_data  (out_data)
	);

	exec_checker chk_i (
		.I_clk     (I_clk),
		.I_reset   (I_reset),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_data   (in_data),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_data  (out_data),
		.test_id   (test_id),
		.end_test  (end_test),
		.pending   (pending),
		.checks    (checks),
		.errors    (errors)
	);

	// ######################################################################
	// stimulus helpers
	// ######################################################################

	// fibonacci lfsr with taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_stim = lfsr_next(lfsr_stim);
			v = {v[30:0], lfsr_stim[0]};
		end
		return v;
	endfunction

	function automatic exec_req_t make_req(input alu_op_e op, input a_sel_e a_sel,
		input b_sel_e b_sel, input br_cond_e cond, input logic [`EXEC_XLEN-1:0] rs1,
		input logic [`EXEC_XLEN-1:0] rs2, input logic [`EXEC_XLEN-1:0] imm);
		exec_req_t   r;
		logic [31:0] t;
		t       = rand_bits(`EXEC_RD_W);
		r.rd    = t[`EXEC_RD_W-1:0];
		t       = rand_bits(32);
		r.pc    = {t[31:2], 2'b00};
		r.op    = op;
		r.a_sel = a_sel;
		r.b_sel = b_sel;
		r.cond  = cond;
		r.rs1   = rs1;
		r.rs2   = rs2;
		r.imm   = imm;
		return r;
	endfunction

	task automatic send_req(input exec_req_t r);
		@(negedge I_clk);
		in_valid = 1'b1;
		in_data  = r;
		@(posedge I_clk);
		while (!in_ready) begin
			@(posedge I_clk);
		end
	endtask

	// drain all outstanding responses, then let the checker report
	task automatic finish_test();
		@(negedge I_clk);
		in_valid = 1'b0;
		while (pending != 0) begin
			@(negedge I_clk);
		end
		end_test = 1'b1;
		@(negedge I_clk);
		end_test = 1'b0;
		test_id  = test_id + 1;
	endtask

	// ######################################################################
	// clock, output throttling, timeout
	// ######################################################################

	initial begin
		I_clk = 1'b0;
		forever #5 I_clk = ~I_clk;
	end

	// long low runs, short high runs
	always @(negedge I_clk) begin
		logic [4:0] len;
		if (!throttle) begin
			out_ready = 1'b1;
		end else if (run_left != 0) begin
			run_left = run_left - 1;
		end else begin
			for (int i = 0; i < 5; i++) begin
				lfsr_bp = lfsr_next(lfsr_bp);
				len = {len[3:0], lfsr_bp[0]};
			end
			out_ready = !out_ready;
			run_left  = out_ready ? int'(len[1:0]) : int'(len) + 4;
		end
	end

	always @(posedge I_clk) begin
		cycles = cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: run stopped after %0d cycles, %0d requests outstanding",
				cycles, pending);
			$display("Done: errors found");
			$finish;
		end
	end

	// ######################################################################
	// test sequence
	// ######################################################################

	initial begin
		logic [31:0] x;
		logic [31:0] y;
		logic [31:0] z;
		logic [31:0] w;
		logic [31:0] va;
		logic [31:0] vb;
		I_reset  = 1'b1;
		in_valid = 1'b0;
		in_data  = '0;
		test_id  = 0;
		end_test = 1'b0;
		throttle = 1'b0;
		repeat (RESET_CYCLES) @(posedge I_clk);
		@(negedge I_clk);
		I_reset = 1'b0;
		// reset state is sampled by the checker on the first edge
		finish_test();

		for (int i = 0; i < 40; i++) begin
			x = rand_bits(32);
			y = rand_bits(32);
			z = rand_bits(32);
			w = rand_bits(2);
			send_req(make_req(ARITH_OPS[i % 5], a_sel_e'(w[0]), b_sel_e'(w[1]), BR_NONE,
				x, y, z));
		end
		finish_test();

		for (int i = 0; i < 3; i++) begin
			x = rand_bits(32);
			case (i)
				0: begin
					va = 32'h80000000;
					vb = 32'h1;
				end
				1: begin
					va = 32'hffffffff;
					vb = 32'h0;
				end
				default: begin
					va = x;
					vb = x;
				end
			endcase
			// both ops, both operand orders
			for (int k = 0; k < 4; k++) begin
				send_req(make_req(k[0] ? OP_SLTU : OP_SLT, A_RS1, B_RS2, BR_NONE,
					k[1] ? vb : va, k[1] ? va : vb, '0));
			end
		end
		for (int i = 0; i < 16; i++) begin
			x = rand_bits(32);
			y = rand_bits(32);
			send_req(make_req(i[0] ? OP_SLTU : OP_SLT, A_RS1, B_RS2, BR_NONE, x, y, '0));
		end
		finish_test();

		// upper bits of rs2 are noise
		for (int k = 0; k < 3; k++) begin
			for (int s = 0; s < 32; s++) begin
				for (int i = 0; i < 2; i++) begin
					x = rand_bits(32);
					y = rand_bits(32);
					send_req(make_req(SHIFT_OPS[k], A_RS1, B_RS2, BR_NONE,
						{i[0], x[30:0]}, {y[31:5], s[4:0]}, '0));
				end
			end
		end
		finish_test();

		for (int k = 0; k < 6; k++) begin
			for (int i = 0; i < 4; i++) begin
				for (int s = 0; s < 2; s++) begin
					x = rand_bits(32);
					send_req(make_req(OP_SUB, A_RS1, B_RS2, BR_CONDS[k], BR_A[i], BR_B[i],
						{x[31:2], s[0], 1'b0}));
				end
			end
		end
		finish_test();

		@(posedge I_clk);
		throttle = 1'b1;
		for (int i = 0; i < 40; i++) begin
			x = rand_bits(32);
			y = rand_bits(32);
			z = rand_bits(32);
			w = rand_bits(9);
			send_req(make_req(ALL_OPS[w[3:0] % 10], a_sel_e'(w[7]), b_sel_e'(w[8]),
				(w[6:4] == 3'd7) ? BR_NONE : br_cond_e'(w[6:4]), x, y, z));
		end
		finish_test();

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire
